// File: build.f
dcache_pkg.sv
line_ram.sv
dcache_ways.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - line_ram.sv
  - dcache_ways.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int MEM_WORDS    = 4096;
    localparam int N_ROWS       = 20;
    localparam int CLEAR_CYCLES = 256 + 8;
    localparam int CYCLE_LIMIT  = N_ROWS * 20 + CLEAR_CYCLES;

    localparam logic [1:0] RD_NO  = 2'd0;
    localparam logic [1:0] RD_YES = 2'd1;
    localparam logic [1:0] RD_ANY = 2'd2;  // victim is random

    logic          clk;
    logic          rst;
    logic          req_valid;
    logic          req_write;
    logic [31:0]   req_addr;
    logic [31:0]   req_wdata;
    logic [3:0]    req_wstrb;
    logic          req_ready;
    logic          resp_valid;
    logic [31:0]   resp_rdata;
    logic          mem_rd_valid;
    logic [31:0]   mem_rd_addr;
    logic          mem_rd_ready  = 1'b0;
    logic          mem_ret_valid = 1'b0;
    logic [127:0]  mem_ret_data  = '0;
    logic          mem_wr_valid;
    logic [31:0]   mem_wr_addr;
    logic [127:0]  mem_wr_data;
    logic [15:0]   mem_wr_strb;
    logic          mem_wr_ready  = 1'b0;

    logic [31:0] mem [MEM_WORDS];
    int          seed        = 57539;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          rd_count    = 0;
    int          wr_count    = 0;
    int          ret_wait    = 0;
    logic [31:0] ret_addr    = '0;

    // request in flight, seen by the bus checks
    logic        cur_write;
    logic [31:0] cur_addr;
    logic [31:0] cur_wdata;
    logic [3:0]  cur_wstrb;

    logic        row_write  [N_ROWS];
    logic [31:0] row_addr   [N_ROWS];
    logic [31:0] row_wdata  [N_ROWS];
    logic [3:0]  row_wstrb  [N_ROWS];
    logic [1:0]  row_bus_rd [N_ROWS];
    int          row_count;

    dcache_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_wstrb    (req_wstrb),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_ready (mem_rd_ready),
        .mem_ret_valid(mem_ret_valid),
        .mem_ret_data (mem_ret_data),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_strb  (mem_wr_strb),
        .mem_wr_ready (mem_wr_ready)
    );

    always #50 clk = ~clk;

    function automatic logic [127:0] model_line(input logic [31:0] addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[32*w +: 32] = mem[{addr[13:4], 2'(w)}];
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] wstrb,
                           input logic [1:0] bus_rd);
        row_write[row_count]  = write;
        row_addr[row_count]   = addr;
        row_wdata[row_count]  = wdata;
        row_wstrb[row_count]  = wstrb;
        row_bus_rd[row_count] = bus_rd;
        row_count++;
    endtask

    // bus side memory, decides each handshake for the coming rising edge
    always @(negedge clk) begin : memory_model
        logic [11:0] idx;
        if (rst) begin
            mem_rd_ready  = 1'b0;
            mem_wr_ready  = 1'b0;
            mem_ret_valid = 1'b0;
            ret_wait      = 0;
        end else begin
            mem_ret_valid = 1'b0;
            if (ret_wait != 0) begin
                ret_wait--;
                if (ret_wait == 0) begin
                    mem_ret_valid = 1'b1;
                    mem_ret_data  = model_line(ret_addr);
                end
            end
            mem_rd_ready = ($unsigned($random(seed)) % 4) != 0;  // ready 3 of 4
            mem_wr_ready = ($unsigned($random(seed)) % 4) != 0;
            if (mem_rd_valid && mem_rd_ready) begin
                rd_count++;
                check_value("mem_rd_addr", mem_rd_addr, {cur_addr[31:4], 4'h0});
                ret_addr = mem_rd_addr;
                ret_wait = 1 + $unsigned($random(seed)) % 4;
            end
            if (mem_wr_valid && mem_wr_ready) begin
                wr_count++;
                check_value("mem_wr_addr", mem_wr_addr, cur_addr);
                check_value("mem_wr_data", mem_wr_data, 128'(cur_wdata) << (32 * cur_addr[3:2]));
                check_value("mem_wr_strb", mem_wr_strb, 16'(cur_wstrb) << (4 * cur_addr[3:2]));
                for (int b = 0; b < 16; b++) begin
                    if (mem_wr_strb[b]) begin
                        idx = {mem_wr_addr[13:4], 2'(b / 4)};
                        mem[idx][8*(b%4) +: 8] = mem_wr_data[8*b +: 8];
                    end
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: no response within %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] exp_word;
        int          rd_before;
        int          wr_before;

        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        cur_write = 1'b0;
        cur_addr  = '0;
        cur_wdata = '0;
        cur_wstrb = '0;
        row_count = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) << 18) ^ (32'(i) * 32'h9e37) ^ 32'h5a5a_0000;
        end

        add_row(1'b0, 32'h0000_0104, 32'h0, 4'h0, RD_YES);  // cold miss
        add_row(1'b0, 32'h0000_010c, 32'h0, 4'h0, RD_NO);
        add_row(1'b0, 32'h0000_1108, 32'h0, 4'h0, RD_YES);  // second tag, same set
        add_row(1'b0, 32'h0000_1100, 32'h0, 4'h0, RD_NO);
        add_row(1'b1, 32'h0000_1104, 32'hdead_beef, 4'b0110, RD_NO);  // partial write hit
        add_row(1'b0, 32'h0000_1104, 32'h0, 4'h0, RD_NO);
        add_row(1'b1, 32'h0000_2208, 32'h1234_5678, 4'b1111, RD_NO);  // write miss
        add_row(1'b0, 32'h0000_2208, 32'h0, 4'h0, RD_YES);  // no allocate
        add_row(1'b0, 32'h0000_220c, 32'h0, 4'h0, RD_NO);
        add_row(1'b0, 32'h0000_0300, 32'h0, 4'h0, RD_ANY);  // three tags in set 0x30
        add_row(1'b0, 32'h0000_1304, 32'h0, 4'h0, RD_ANY);
        add_row(1'b0, 32'h0000_2308, 32'h0, 4'h0, RD_ANY);
        add_row(1'b1, 32'h0000_130c, 32'hcafe_f00d, 4'b1001, RD_NO);
        add_row(1'b0, 32'h0000_130c, 32'h0, 4'h0, RD_ANY);
        add_row(1'b0, 32'h0000_0304, 32'h0, 4'h0, RD_ANY);
        add_row(1'b0, 32'h0000_2300, 32'h0, 4'h0, RD_ANY);
        add_row(1'b0, 32'h0000_1308, 32'h0, 4'h0, RD_ANY);
        add_row(1'b0, 32'h0000_030c, 32'h0, 4'h0, RD_ANY);
        add_row(1'b0, 32'h0000_2304, 32'h0, 4'h0, RD_ANY);
        add_row(1'b0, 32'h0000_0100, 32'h0, 4'h0, RD_ANY);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (!req_ready) @(negedge clk);  // set sweep

        for (int r = 0; r < row_count; r++) begin
            cur_write = row_write[r];
            cur_addr  = row_addr[r];
            cur_wdata = row_wdata[r];
            cur_wstrb = row_wstrb[r];
            rd_before = rd_count;
            wr_before = wr_count;
            req_valid = 1'b1;
            req_write = cur_write;
            req_addr  = cur_addr;
            req_wdata = cur_wdata;
            req_wstrb = cur_wstrb;
            @(posedge clk);  // accepted, cache is idle
            @(negedge clk);
            req_valid = 1'b0;
            @(posedge clk);
            while (!resp_valid) @(posedge clk);
            exp_word = cur_write ? 32'h0 : mem[cur_addr[13:2]];
            check_value("resp_rdata", resp_rdata, exp_word);
            check_value("bus write count", wr_count - wr_before, cur_write);
            if (row_bus_rd[r] != RD_ANY) begin
                check_value("bus read count", rd_count - rd_before, row_bus_rd[r]);
            end
            @(negedge clk);
            // one response cycle, then idle
            check_value("resp_valid", resp_valid, 1'b0);
            check_value("req_ready", req_ready, 1'b1);
            while (!req_ready) @(negedge clk);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                               clk,
    input  logic                               rst,

    // cpu side
    input  logic                               req_valid,
    input  logic                               req_write,
    input  logic [dcache_pkg::ADDR_W-1:0]      req_addr,
    input  logic [dcache_pkg::WORD_W-1:0]      req_wdata,
    input  logic [dcache_pkg::STRB_W-1:0]      req_wstrb,
    output logic                               req_ready,
    output logic                               resp_valid,
    output logic [dcache_pkg::WORD_W-1:0]      resp_rdata,

    // bus read channel
    output logic                               mem_rd_valid,
    output logic [dcache_pkg::ADDR_W-1:0]      mem_rd_addr,
    input  logic                               mem_rd_ready,
    input  logic                               mem_ret_valid,
    input  logic [dcache_pkg::LINE_W-1:0]      mem_ret_data,

    // bus write channel
    output logic                               mem_wr_valid,
    output logic [dcache_pkg::ADDR_W-1:0]      mem_wr_addr,
    output logic [dcache_pkg::LINE_W-1:0]      mem_wr_data,
    output logic [dcache_pkg::LINE_STRB_W-1:0] mem_wr_strb,
    input  logic                               mem_wr_ready
);
    import dcache_pkg::*;

    logic               hit;
    logic [WORD_W-1:0]  hit_word;
    logic               lookup_valid;
    logic               clear_en;
    logic [INDEX_W-1:0] clear_index;
    logic               refill_en;
    logic               refill_way;
    line_u              refill_line;
    logic               store_en;
    logic [WORD_W-1:0]  store_wdata;
    logic [STRB_W-1:0]  store_wstrb;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_wstrb    (req_wstrb),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .hit          (hit),
        .hit_word     (hit_word),
        .lookup_valid (lookup_valid),
        .clear_en     (clear_en),
        .clear_index  (clear_index),
        .refill_en    (refill_en),
        .refill_way   (refill_way),
        .refill_line  (refill_line),
        .store_en     (store_en),
        .store_wdata  (store_wdata),
        .store_wstrb  (store_wstrb),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_ready (mem_rd_ready),
        .mem_ret_valid(mem_ret_valid),
        .mem_ret_data (mem_ret_data),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_strb  (mem_wr_strb),
        .mem_wr_ready (mem_wr_ready)
    );

    // lookup reads the arrays in the accept cycle
    dcache_ways u_ways (
        .clk         (clk),
        .rst         (rst),
        .lookup_valid(lookup_valid),
        .lookup_addr (req_addr),
        .clear_en    (clear_en),
        .clear_index (clear_index),
        .refill_en   (refill_en),
        .refill_way  (refill_way),
        .refill_line (refill_line),
        .store_en    (store_en),
        .store_wdata (store_wdata),
        .store_wstrb (store_wstrb),
        .hit         (hit),
        .hit_word    (hit_word)
    );

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req_valid,
    input  logic                               req_write,
    input  logic [dcache_pkg::ADDR_W-1:0]      req_addr,
    input  logic [dcache_pkg::WORD_W-1:0]      req_wdata,
    input  logic [dcache_pkg::STRB_W-1:0]      req_wstrb,
    output logic                               req_ready,
    output logic                               resp_valid,
    output logic [dcache_pkg::WORD_W-1:0]      resp_rdata,
    input  logic                               hit,
    input  logic [dcache_pkg::WORD_W-1:0]      hit_word,
    output logic                               lookup_valid,
    output logic                               clear_en,
    output logic [dcache_pkg::INDEX_W-1:0]     clear_index,
    output logic                               refill_en,
    output logic                               refill_way,
    output dcache_pkg::line_u                  refill_line,
    output logic                               store_en,
    output logic [dcache_pkg::WORD_W-1:0]      store_wdata,
    output logic [dcache_pkg::STRB_W-1:0]      store_wstrb,
    output logic                               mem_rd_valid,
    output logic [dcache_pkg::ADDR_W-1:0]      mem_rd_addr,
    input  logic                               mem_rd_ready,
    input  logic                               mem_ret_valid,
    input  logic [dcache_pkg::LINE_W-1:0]      mem_ret_data,
    output logic                               mem_wr_valid,
    output logic [dcache_pkg::ADDR_W-1:0]      mem_wr_addr,
    output logic [dcache_pkg::LINE_W-1:0]      mem_wr_data,
    output logic [dcache_pkg::LINE_STRB_W-1:0] mem_wr_strb,
    input  logic                               mem_wr_ready
);
    import dcache_pkg::*;

    logic [STATE_W-1:0]                state;
    logic [STATE_W-1:0]                state_nxt;
    logic [INDEX_W-1:0]                clear_cnt;
    logic [15:0]                       lfsr;
    logic                              write_q;
    logic [ADDR_W-1:0]                 addr_q;
    logic [WORD_W-1:0]                 wdata_q;
    logic [STRB_W-1:0]                 wstrb_q;
    logic [$clog2(WORDS_PER_LINE)-1:0] wsel;
    line_u                             wr_line;

    assign req_ready    = (state == ST_IDLE);
    assign lookup_valid = req_valid && req_ready;
    assign wsel         = addr_q[OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_CLEAR;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_cnt <= '0;
        end else if (clear_en) begin
            clear_cnt <= clear_cnt + 1'b1;
        end
    end

    // x^16 + x^14 + x^13 + x^11, free running
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            write_q <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_CLEAR: begin
                if (clear_cnt == INDEX_W'(NSET - 1)) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (req_valid) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (write_q) begin
                    state_nxt = ST_WRITE_REQ;  // write-through, hit or not
                end else if (hit) begin
                    state_nxt = ST_IDLE;
                end else begin
                    state_nxt = ST_READ_REQ;
                end
            end
            ST_READ_REQ: begin
                if (mem_rd_ready) begin
                    state_nxt = ST_READ_WAIT;
                end
            end
            ST_READ_WAIT: begin
                if (mem_ret_valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_WRITE_REQ: begin
                if (mem_wr_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    assign clear_en    = (state == ST_CLEAR);
    assign clear_index = clear_cnt;

    assign refill_en   = (state == ST_READ_WAIT) && mem_ret_valid;
    assign refill_way  = lfsr[0];  // random victim
    assign refill_line = line_u'(mem_ret_data);

    assign store_en    = (state == ST_WRITE_REQ) && mem_wr_ready;
    assign store_wdata = wdata_q;
    assign store_wstrb = wstrb_q;

    // line read, aligned
    assign mem_rd_valid = (state == ST_READ_REQ);
    assign mem_rd_addr  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_comb begin
        wr_line             = '0;
        wr_line.words[wsel] = wdata_q;  // word in its lane
    end

    assign mem_wr_valid = (state == ST_WRITE_REQ);
    assign mem_wr_addr  = addr_q;
    assign mem_wr_data  = wr_line.bits;
    assign mem_wr_strb  = LINE_STRB_W'(wstrb_q) << (wsel * STRB_W);

    always_comb begin
        resp_valid = 1'b0;
        resp_rdata = '0;
        case (state)
            ST_LOOKUP: begin
                if (!write_q && hit) begin
                    resp_valid = 1'b1;
                    resp_rdata = hit_word;
                end
            end
            ST_READ_WAIT: begin
                if (mem_ret_valid) begin
                    resp_valid = 1'b1;
                    resp_rdata = refill_line.words[wsel];  // bypass the refill
                end
            end
            ST_WRITE_REQ: begin
                resp_valid = mem_wr_ready;
            end
            default: begin
                resp_valid = 1'b0;
            end
        endcase
    end

    // idle again right after the response
    a_resp_when_busy: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !req_ready ##1 req_ready);

    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        mem_rd_valid && !mem_rd_ready |=> mem_rd_valid && $stable(mem_rd_addr));

    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wr_valid && !mem_wr_ready |=> mem_wr_valid && $stable(mem_wr_addr)
            && $stable(mem_wr_data) && $stable(mem_wr_strb));

endmodule

// File: dcache_ways.sv
`timescale 1ns/1ps

module dcache_ways (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           lookup_valid,
    input  logic [dcache_pkg::ADDR_W-1:0]  lookup_addr,
    input  logic                           clear_en,
    input  logic [dcache_pkg::INDEX_W-1:0] clear_index,
    input  logic                           refill_en,
    input  logic                           refill_way,
    input  dcache_pkg::line_u              refill_line,
    input  logic                           store_en,
    input  logic [dcache_pkg::WORD_W-1:0]  store_wdata,
    input  logic [dcache_pkg::STRB_W-1:0]  store_wstrb,
    output logic                           hit,
    output logic [dcache_pkg::WORD_W-1:0]  hit_word
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]                  tag_q;
    logic [INDEX_W-1:0]                index_q;
    logic [$clog2(WORDS_PER_LINE)-1:0] word_q;
    logic                              lookup_q;

    logic [INDEX_W-1:0]     ram_index;
    logic [NWAY-1:0]        way_hit;
    logic [TAG_ENTRY_W-1:0] tag_rdata [NWAY];
    line_u                  data_rdata [NWAY];

    // request fields for the rest of the access
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            tag_q   <= lookup_addr[ADDR_W-1 -: TAG_W];
            index_q <= lookup_addr[OFFSET_W +: INDEX_W];
            word_q  <= lookup_addr[OFFSET_W-1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_valid;
        end
    end

    always_comb begin
        if (lookup_valid) begin
            ram_index = lookup_addr[OFFSET_W +: INDEX_W];
        end else if (clear_en) begin
            ram_index = clear_index;
        end else begin
            ram_index = index_q;  // refill and store go to the looked-up set
        end
    end

    for (genvar i = 0; i < NWAY; i++) begin : g_way
        logic                   refill_sel;
        logic                   store_sel;
        logic                   tag_en;
        logic                   tag_we;
        logic [TAG_ENTRY_W-1:0] tag_wdata;
        logic                   data_en;
        logic                   data_we;
        line_u                  merged;
        line_u                  data_wdata;

        assign way_hit[i] = tag_rdata[i][TAG_W] && (tag_rdata[i][TAG_W-1:0] == tag_q);

        assign refill_sel = refill_en && (refill_way == 1'(i));
        assign store_sel  = store_en && way_hit[i];  // store misses leave the line alone

        assign tag_en    = lookup_valid || clear_en || refill_sel;
        assign tag_we    = clear_en || refill_sel;
        assign tag_wdata = clear_en ? '0 : {1'b1, tag_q};

        // byte merge into the held line
        always_comb begin
            merged = data_rdata[i];
            for (int b = 0; b < STRB_W; b++) begin
                if (store_wstrb[b]) begin
                    merged.words[word_q][8*b +: 8] = store_wdata[8*b +: 8];
                end
            end
        end

        assign data_en    = lookup_valid || refill_sel || store_sel;
        assign data_we    = refill_sel || store_sel;
        assign data_wdata = refill_sel ? refill_line : merged;

        line_ram #(
            .DATA_W(TAG_ENTRY_W),
            .DEPTH (NSET)
        ) u_tag_ram (
            .clk  (clk),
            .en   (tag_en),
            .we   (tag_we),
            .addr (ram_index),
            .wdata(tag_wdata),
            .rdata(tag_rdata[i])
        );

        line_ram #(
            .DATA_W(LINE_W),
            .DEPTH (NSET)
        ) u_data_ram (
            .clk  (clk),
            .en   (data_en),
            .we   (data_we),
            .addr (ram_index),
            .wdata(data_wdata.bits),
            .rdata(data_rdata[i].bits)
        );
    end

    assign hit = |way_hit;

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (way_hit[w]) begin
                hit_word = data_rdata[w].words[word_q];
            end
        end
    end

    // a refill only follows a miss in both ways
    a_single_way_hit: assert property (@(posedge clk) disable iff (rst)
        lookup_q |-> $onehot0(way_hit));

    a_refill_store_excl: assert property (@(posedge clk) disable iff (rst)
        !(refill_en && store_en));

endmodule

// File: line_ram.sv
`timescale 1ns/1ps

module line_ram #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 256
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [DATA_W-1:0]        wdata,
    output logic [DATA_W-1:0]        rdata
);

    logic [DATA_W-1:0] mem [DEPTH];

    // one port, either write or read per enabled cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // held until next enabled read
            end
        end
    end

endmodule

// File: dcache_pkg.sv
package dcache_pkg;

    // address split: tag | index | offset
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;  // bits 3:2 pick the word

    localparam int NSET = 256;
    localparam int NWAY = 2;

    localparam int WORD_W = 32;
    localparam int STRB_W = 4;

    localparam int LINE_W         = 128;
    localparam int LINE_STRB_W    = 16;
    localparam int WORDS_PER_LINE = 4;

    // valid bit sits above the tag
    localparam int TAG_ENTRY_W = TAG_W + 1;

    // one cache line, raw or split into words
    typedef union packed {
        logic [LINE_W-1:0]                     bits;
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
    } line_u;

    // controller states
    localparam int STATE_W = 3;

    localparam logic [STATE_W-1:0] ST_CLEAR     = 3'd0;  // invalidate sweep
    localparam logic [STATE_W-1:0] ST_IDLE      = 3'd1;
    localparam logic [STATE_W-1:0] ST_LOOKUP    = 3'd2;
    localparam logic [STATE_W-1:0] ST_READ_REQ  = 3'd3;
    localparam logic [STATE_W-1:0] ST_READ_WAIT = 3'd4;
    localparam logic [STATE_W-1:0] ST_WRITE_REQ = 3'd5;

endpackage
